/* bench/router_switch_tb.sv */
// Directed testbench for the switch stage; stops at the first failed check.
// The model keeps one round-robin pointer per output, as a candidate slot 0 to 3.
`timescale 1ns/1ps
`default_nettype none

module router_switch_tb;

        import noc_types_pkg::*;
        import arb_cfg_pkg::*;

        localparam int MAX_CYCLES = 4000;               // Whole run needs a few hundred.

        logic                  clk;
        logic                  rst_n;
        apb_req_t              apb_req;
        apb_rsp_t              apb_rsp;
        flit_t [NUM_PORTS-1:0] in_flit;
        logic  [NUM_PORTS-1:0] in_ready;
        flit_t [NUM_PORTS-1:0] out_flit;
        logic  [NUM_PORTS-1:0] out_ready;
        logic  [15:0]          lfsr;
        int                    rr_ptr [NUM_PORTS];      // Model pointer per output.
        int                    cnt_exp [NUM_PORTS];     // Flits delivered per output.
        int                    left_n [NUM_PORTS];      // Flits still to offer per input.
        int                    cycles = 0;
        string                 test_name;

        router_switch_top router_switch_top_i (
                .clk         (clk),
                .rst_n_i     (rst_n),
                .apb_req_i   (apb_req),
                .apb_rsp_o   (apb_rsp),
                .in_flit_i   (in_flit),
                .in_ready_o  (in_ready),
                .out_flit_o  (out_flit),
                .out_ready_i (out_ready)
        );

        initial clk = 1'b0;
        always #5 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout: the run did not finish within %0d cycles.", cycles);
                        $display("TEST FAILED");
                        $fatal(1, "Stopped by the cycle limit.");
                end
        end

        task automatic fail_value(input string what, input int exp_v, input int act_v);
                $display("error: %s: %s expected 0x%0h, actual 0x%0h",
                         test_name, what, exp_v, act_v);
                $display("TEST FAILED");
                $fatal(1, "Stopped at the first mismatch.");
        endtask

        task automatic fail_text(input string what);
                $display("%s: %s", test_name, what);
                $display("TEST FAILED");
                $fatal(1, "Stopped at the first failed check.");
        endtask

        // Galois LFSR, one step per bit taken.
        function automatic logic [15:0] rand_bits(input int n);
                logic [15:0] r;
                logic        b;
                r = '0;
                for (int k = 0; k < n; k++) begin
                        b    = lfsr[0];
                        lfsr = lfsr >> 1;
                        if (b) lfsr = lfsr ^ 16'hB400;
                        r = {r[14:0], b};
                end
                return r;
        endfunction

        // Candidate slots run N S W E L with output o left out.
        function automatic int port_of_slot(input int o, input int slot);
                int seen;
                seen = 0;
                for (int p = 0; p < NUM_PORTS; p++) begin
                        if (p != o) begin
                                if (seen == slot) return p;
                                seen++;
                        end
                end
                return -1;
        endfunction

        function automatic int expected_winner(input int o, input logic [NUM_PORTS-1:0] req);
                int p;
                for (int step = 0; step < NUM_PORTS - 1; step++) begin
                        p = port_of_slot(o, (rr_ptr[o] + step) % (NUM_PORTS - 1));
                        if (req[p]) return p;
                end
                return -1;
        endfunction

        function automatic void advance_ptr(input int o, input int winner);
                rr_ptr[o] = ((winner < o) ? winner + 1 : winner) % (NUM_PORTS - 1);
        endfunction

        function automatic logic [NUM_PORTS-1:0] pending_mask();
                logic [NUM_PORTS-1:0] m;
                for (int i = 0; i < NUM_PORTS; i++) m[i] = (left_n[i] > 0);
                return m;
        endfunction

        task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata, output logic err);
                @(posedge clk);
                apb_req.psel    <= 1'b1;                // Setup phase.
                apb_req.penable <= 1'b0;
                apb_req.pwrite  <= wr;
                apb_req.paddr   <= addr;
                apb_req.pwdata  <= wdata;
                @(posedge clk);
                apb_req.penable <= 1'b1;
                @(negedge clk);
                assert (!apb_rsp.pready) else fail_text("pready rose without a wait state.");
                @(negedge clk);                         // Second access cycle.
                assert (apb_rsp.pready)
                        else fail_text("pready did not rise in the second access cycle.");
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                @(posedge clk);                         // Transfer completes here.
                apb_req.psel    <= 1'b0;
                apb_req.penable <= 1'b0;
        endtask

        task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
                logic [DATA_W-1:0] rd;
                logic              err;
                apb_xfer(1'b1, addr, data, rd, err);
                assert (!err) else fail_text("A write to a mapped address gave pslverr.");
        endtask

        task automatic apb_check_read(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] exp_v);
                logic [DATA_W-1:0] rd;
                logic              err;
                apb_xfer(1'b0, addr, '0, rd, err);
                assert (!err) else fail_text("A read of a mapped address gave pslverr.");
                assert (rd == exp_v)
                        else fail_value($sformatf("read of 0x%02h", addr), int'(exp_v), int'(rd));
        endtask

        task automatic send_flit(input int src, input dir_e dir, input logic [PAYLOAD_W-1:0] pl);
                @(posedge clk);
                in_flit[src].valid    <= 1'b1;
                in_flit[src].next_dir <= dir;
                in_flit[src].payload  <= pl;
                do @(negedge clk); while (!in_ready[src]);
                assert (in_ready == NUM_PORTS'(1 << src))
                        else fail_value("in_ready", 1 << src, int'(in_ready));
                @(posedge clk);                         // Accepted at this edge.
                in_flit[src].valid <= 1'b0;
                cnt_exp[int'(dir)]++;
        endtask

        // Only output dst may hold a flit, and it must carry pl.
        task automatic check_output(input int dst, input logic [PAYLOAD_W-1:0] pl);
                for (int o = 0; o < NUM_PORTS; o++) begin
                        assert (out_flit[o].valid == (o == dst))
                                else fail_value($sformatf("out_flit[%0d].valid", o),
                                                int'(o == dst), int'(out_flit[o].valid));
                end
                if (dst >= 0) begin                     // A negative dst expects none.
                        assert (out_flit[dst].payload == pl)
                                else fail_value("payload", int'(pl),
                                                int'(out_flit[dst].payload));
                        assert (out_flit[dst].next_dir == dir_e'(dst))
                                else fail_value("next_dir", dst, int'(out_flit[dst].next_dir));
                end
        endtask

        task automatic offer_north(input logic [NUM_PORTS-1:0] who, input int quota);
                @(posedge clk);
                for (int i = 0; i < NUM_PORTS; i++) begin
                        left_n[i] = who[i] ? quota : 0;
                        if (who[i]) begin
                                in_flit[i].valid    <= 1'b1;
                                in_flit[i].next_dir <= DIR_N;
                                in_flit[i].payload  <= rand_bits(PAYLOAD_W);
                        end
                end
        endtask

        // Each grant must match the model; each winner's payload shows up a cycle later.
        task automatic drain_north(input logic rot);
                logic [PAYLOAD_W-1:0] last_pl;
                logic                 have_last;
                logic [NUM_PORTS-1:0] req;
                int                   win;
                have_last = 1'b0;
                last_pl   = '0;
                req       = pending_mask();
                while (req != '0) begin
                        @(negedge clk);
                        if (have_last) check_output(0, last_pl);
                        win = expected_winner(0, req);
                        assert (in_ready == NUM_PORTS'(1 << win))
                                else fail_value("in_ready", 1 << win, int'(in_ready));
                        last_pl   = in_flit[win].payload;
                        have_last = 1'b1;
                        @(posedge clk);
                        if (rot) advance_ptr(0, win);
                        cnt_exp[0]++;
                        left_n[win]--;
                        if (left_n[win] > 0) in_flit[win].payload <= rand_bits(PAYLOAD_W);
                        else in_flit[win].valid <= 1'b0;
                        req = pending_mask();
                end
                @(negedge clk);
                check_output(0, last_pl);
        endtask

        task automatic reset_and_registers();
                logic [DATA_W-1:0] rd;
                logic              err;
                test_name = "reset_regs";
                @(negedge clk);
                assert (in_ready == '0 && !apb_rsp.pready && !apb_rsp.pslverr)
                        else fail_text("Handshake outputs are not low after reset.");
                check_output(-1, '0);
                apb_check_read(REG_CTRL, 32'h0);
                apb_write(REG_CTRL, 32'h3);
                apb_check_read(REG_CTRL, 32'h3);
                apb_xfer(1'b0, 8'h40, '0, rd, err);
                assert (err) else fail_text("An unmapped address returned no pslverr.");
        endtask

        task automatic route_every_pair();
                logic [PAYLOAD_W-1:0] pl;
                test_name = "routing";
                apb_write(REG_CTRL, 32'h1);             // Enable, fixed pointers.
                for (int src = 0; src < NUM_PORTS; src++) begin
                        for (int dst = 0; dst < NUM_PORTS; dst++) begin
                                if (dst != src) begin
                                        pl = rand_bits(PAYLOAD_W);
                                        send_flit(src, dir_e'(dst), pl);
                                        @(negedge clk);
                                        check_output(dst, pl);
                                end
                        end
                end
        endtask

        task automatic rotating_order();
                test_name = "fairness";
                apb_write(REG_CTRL, 32'h3);
                offer_north(5'b11110, 3);
                drain_north(1'b1);
        endtask

        task automatic frozen_order();
                test_name = "frozen";
                apb_write(REG_CTRL, 32'h1);
                offer_north(5'b11110, 3);
                drain_north(1'b0);
        endtask

        task automatic stall_and_disable();
                logic [PAYLOAD_W-1:0] pl;
                test_name = "backpressure";
                apb_write(REG_CTRL, 32'h3);
                @(posedge clk);
                out_ready[0] <= 1'b0;
                pl = rand_bits(PAYLOAD_W);
                send_flit(1, DIR_N, pl);
                advance_ptr(0, 1);
                offer_north(5'b11100, 1);
                repeat (6) begin
                        @(negedge clk);
                        check_output(0, pl);            // Held while stalled.
                        assert (in_ready == '0)
                                else fail_value("in_ready while stalled", 0, int'(in_ready));
                end
                @(posedge clk);
                out_ready[0] <= 1'b1;
                drain_north(1'b1);
                test_name = "enable_off";
                apb_write(REG_CTRL, 32'h0);
                @(posedge clk);
                in_flit[4].valid    <= 1'b1;
                in_flit[4].next_dir <= DIR_E;
                in_flit[4].payload  <= rand_bits(PAYLOAD_W);
                repeat (8) begin
                        @(negedge clk);
                        assert (in_ready == '0 && !out_flit[3].valid)
                                else fail_text("A flit passed while the switch was disabled.");
                end
                @(posedge clk);
                in_flit[4].valid <= 1'b0;
        endtask

        task automatic read_and_clear_counters();
                logic [ADDR_W-1:0] addr;
                test_name = "counters";
                for (int o = 0; o < NUM_PORTS; o++) begin
                        addr = REG_CNT_BASE + ADDR_W'(4 * o);
                        apb_check_read(addr, DATA_W'(cnt_exp[o]));
                        apb_write(addr, 32'hFFFF_FFFF);  // Any write clears.
                        apb_check_read(addr, 32'h0);
                end
        endtask

        initial begin
                lfsr      = 16'd11103;
                rst_n     = 1'b0;
                apb_req   = '0;
                in_flit   = '0;
                out_ready = '1;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        rr_ptr[o]  = 0;
                        cnt_exp[o] = 0;
                        left_n[o]  = 0;
                end
                repeat (16) @(posedge clk);
                rst_n <= 1'b1;
                reset_and_registers();
                route_every_pair();
                rotating_order();
                frozen_order();
                stall_and_disable();
                read_and_clear_counters();
                $display("TEST PASSED");
                $finish;
        end

endmodule

`default_nettype wire

/* compile.f */
hdl/noc_types_pkg.sv
hdl/arb_cfg_pkg.sv
hdl/out_port_arbiter.sv
hdl/switch_crossbar.sv
hdl/arb_ctrl.sv
hdl/router_switch_top.sv
bench/router_switch_tb.sv

/* hdl/arb_cfg_pkg.sv */
// APB bus types and the register map of the switch control block.
// Counters are read-only. Any write to a counter address clears it.
`default_nettype none

package arb_cfg_pkg;

        localparam int ADDR_W = 8;                      // APB address bits.
        localparam int DATA_W = 32;                     // APB data bits.
        localparam int CNT_W  = 16;                     // Delivery counter bits.

        localparam logic [ADDR_W-1:0] REG_CTRL     = 8'h00;
        localparam logic [ADDR_W-1:0] REG_CNT_BASE = 8'h04;   // Output k at base + 4*k.

        localparam int CTRL_EN_BIT  = 0;                // Switch enable.
        localparam int CTRL_ROT_BIT = 1;                // Round-robin rotate enable.

        typedef struct packed {
                logic              psel;
                logic              penable;
                logic              pwrite;
                logic [ADDR_W-1:0] paddr;
                logic [DATA_W-1:0] pwdata;
        } apb_req_t;

        typedef struct packed {
                logic [DATA_W-1:0] prdata;
                logic              pready;
                logic              pslverr;
        } apb_rsp_t;

        typedef enum logic [1:0] {APB_IDLE, APB_WAIT, APB_RESP} apb_state_e;

endpackage

`default_nettype wire

/* hdl/arb_ctrl.sv */
// APB control slave: enable and rotate bits plus per-output delivery counters.
// Each transfer inserts exactly one wait state; counters saturate at all ones.
`timescale 1ns/1ps
`default_nettype none

module arb_ctrl (
        input  wire                                   clk,
        input  wire                                   rst_n_i,
        input  arb_cfg_pkg::apb_req_t                 apb_req_i,
        output arb_cfg_pkg::apb_rsp_t                 apb_rsp_o,
        input  wire  [noc_types_pkg::NUM_PORTS-1:0]   granted_i,
        output logic                                  enable_o,
        output logic [noc_types_pkg::NUM_PORTS-1:0]   rotate_o
);

        import noc_types_pkg::*;
        import arb_cfg_pkg::*;

        apb_state_e                      state_q, state_d;
        logic                            enable_q;
        logic                            rotate_en_q;
        logic [NUM_PORTS-1:0][CNT_W-1:0] cnt_q;          // Deliveries per output.
        logic                            is_ctrl;
        logic [NUM_PORTS-1:0]            is_cnt;
        logic                            addr_hit;
        logic                            wr_en;
        logic [DATA_W-1:0]               rdata;

        // Setup, then two access cycles; pready rises in the second.
        always_comb begin
                state_d = state_q;
                case (state_q)
                        APB_IDLE: if (apb_req_i.psel && !apb_req_i.penable) state_d = APB_WAIT;
                        APB_WAIT: begin
                                if (apb_req_i.psel && apb_req_i.penable) state_d = APB_RESP;
                                else if (!apb_req_i.psel) state_d = APB_IDLE;
                        end
                        APB_RESP: state_d = APB_IDLE;   // Transfer completes here.
                        default:  state_d = APB_IDLE;
                endcase
        end

        always_comb begin
                is_ctrl = (apb_req_i.paddr == REG_CTRL);
                for (int k = 0; k < NUM_PORTS; k++) begin
                        is_cnt[k] = (apb_req_i.paddr == ADDR_W'(int'(REG_CNT_BASE) + 4 * k));
                end
                addr_hit = is_ctrl || (|is_cnt);
                wr_en    = (state_q == APB_RESP) && apb_req_i.pwrite && addr_hit;
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q     <= APB_IDLE;
                        enable_q    <= 1'b0;
                        rotate_en_q <= 1'b0;
                end else begin
                        state_q <= state_d;
                        if (wr_en && is_ctrl) begin
                                enable_q    <= apb_req_i.pwdata[CTRL_EN_BIT];
                                rotate_en_q <= apb_req_i.pwdata[CTRL_ROT_BIT];
                        end
                end
        end

        // Clear on write wins over a delivery in the same cycle.
        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        cnt_q <= '0;
                end else begin
                        for (int k = 0; k < NUM_PORTS; k++) begin
                                if (wr_en && is_cnt[k]) cnt_q[k] <= '0;
                                else if (granted_i[k] && (cnt_q[k] != '1))
                                        cnt_q[k] <= cnt_q[k] + 1'b1;
                        end
                end
        end

        always_comb begin
                rdata = '0;
                if (state_q == APB_RESP && !apb_req_i.pwrite) begin
                        if (is_ctrl) begin
                                rdata[CTRL_EN_BIT]  = enable_q;
                                rdata[CTRL_ROT_BIT] = rotate_en_q;
                        end
                        for (int k = 0; k < NUM_PORTS; k++) begin
                                if (is_cnt[k]) rdata[CNT_W-1:0] = cnt_q[k];
                        end
                end
        end

        always_comb begin
                apb_rsp_o.prdata  = rdata;
                apb_rsp_o.pready  = (state_q == APB_RESP);
                apb_rsp_o.pslverr = (state_q == APB_RESP) && !addr_hit;
        end

        assign enable_o = enable_q;
        assign rotate_o = granted_i & {NUM_PORTS{rotate_en_q}};    // Advance on each grant.

        a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
                apb_req_i.penable |-> apb_req_i.psel) else $error("APB penable without psel.");

endmodule

`default_nettype wire

/* hdl/noc_types_pkg.sv */
// Router-wide types shared by the arbiters and the crossbar.
// The direction encoding doubles as the port index, N S W E L from 0 to 4.
`default_nettype none

package noc_types_pkg;

        localparam int NUM_PORTS = 5;                   // N, S, W, E, L.
        localparam int PAYLOAD_W = 16;                  // Flit payload bits.
        localparam int NUM_CAND  = NUM_PORTS - 1;       // Inputs an output may serve.
        localparam int PTR_W     = $clog2(NUM_CAND);    // Round-robin pointer width.

        // Next-hop direction, also used as the port index.
        typedef enum logic [2:0] {
                DIR_N = 3'd0,
                DIR_S = 3'd1,
                DIR_W = 3'd2,
                DIR_E = 3'd3,
                DIR_L = 3'd4
        } dir_e;

        // One flit as presented at an input or held in an output register.
        typedef struct packed {
                logic                 valid;
                dir_e                 next_dir;
                logic [PAYLOAD_W-1:0] payload;
        } flit_t;

endpackage

`default_nettype wire

/* hdl/out_port_arbiter.sv */
// Round-robin switch arbiter for one output port.
// Own-side input is never a candidate; U-turn flits are outside the contract.
`timescale 1ns/1ps
`default_nettype none

module out_port_arbiter #(
        parameter noc_types_pkg::dir_e OUT_DIR = noc_types_pkg::DIR_N
) (
        input  wire                                          clk,
        input  wire                                          rst_n_i,
        input  noc_types_pkg::flit_t [noc_types_pkg::NUM_PORTS-1:0] in_flit_i,
        input  wire                                          out_free_i,
        input  wire                                          enable_i,
        input  wire                                          rotate_i,
        output logic [noc_types_pkg::NUM_PORTS-1:0]          grant_o
);

        import noc_types_pkg::*;

        localparam int OUT_IDX = int'(OUT_DIR);

        logic [NUM_PORTS-1:0] req;                      // Inputs heading for this output.
        logic [NUM_CAND-1:0]  cand_req;                 // Same, in candidate order.
        logic [PTR_W-1:0]     ptr_q;                    // Highest-priority candidate.
        logic [PTR_W-1:0]     win_idx;                  // Candidate picked this cycle.
        logic                 hit;

        // Candidate k maps to a port index, skipping our own side
        function automatic int cand_port(input int k);
                return (k < OUT_IDX) ? k : k + 1;
        endfunction

        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        req[i] = in_flit_i[i].valid && (in_flit_i[i].next_dir == OUT_DIR);
                end
                for (int k = 0; k < NUM_CAND; k++) begin
                        cand_req[k] = req[cand_port(k)];
                end
        end

        // Cyclic search starting at the pointer.
        always_comb begin
                int idx;
                hit     = 1'b0;
                win_idx = ptr_q;
                for (int off = 0; off < NUM_CAND; off++) begin
                        idx = (int'(ptr_q) + off) % NUM_CAND;
                        if (!hit && cand_req[idx]) begin
                                hit     = 1'b1;
                                win_idx = PTR_W'(idx);
                        end
                end
        end

        always_comb begin
                grant_o = '0;
                for (int k = 0; k < NUM_CAND; k++) begin
                        if (hit && enable_i && out_free_i && (int'(win_idx) == k)) begin
                                grant_o[cand_port(k)] = 1'b1;
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        ptr_q <= '0;                    // First candidate after reset.
                end else if (rotate_i) begin
                        ptr_q <= (int'(win_idx) == NUM_CAND - 1) ? '0 : win_idx + 1'b1;
                end
        end

        a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
                $onehot0(grant_o)) else $error("Arbiter %0d: grant not one-hot.", OUT_IDX);

        a_no_uturn: assert property (@(posedge clk) disable iff (!rst_n_i)
                in_flit_i[OUT_IDX].valid |-> (in_flit_i[OUT_IDX].next_dir != OUT_DIR))
                else $error("Input %0d names its own side as next hop.", OUT_IDX);

endmodule

`default_nettype wire

/* hdl/router_switch_top.sv */
// Switch-allocation stage of a five-port mesh router.
// Next-hop directions arrive precomputed; no buffering ahead of the arbiters.
`timescale 1ns/1ps
`default_nettype none

module router_switch_top (
        input  wire                                                 clk,
        input  wire                                                 rst_n_i,
        input  arb_cfg_pkg::apb_req_t                               apb_req_i,
        output arb_cfg_pkg::apb_rsp_t                               apb_rsp_o,
        input  noc_types_pkg::flit_t [noc_types_pkg::NUM_PORTS-1:0] in_flit_i,
        output logic [noc_types_pkg::NUM_PORTS-1:0]                 in_ready_o,
        output noc_types_pkg::flit_t [noc_types_pkg::NUM_PORTS-1:0] out_flit_o,
        input  wire  [noc_types_pkg::NUM_PORTS-1:0]                 out_ready_i
);

        import noc_types_pkg::*;

        logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;     // Indexed [output][input].
        logic [NUM_PORTS-1:0]                granted;   // Any grant per output.
        logic [NUM_PORTS-1:0]                out_free;
        logic [NUM_PORTS-1:0]                rotate;
        logic                                enable;

        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
                out_port_arbiter #(
                        .OUT_DIR (dir_e'(o))
                ) u_arb (
                        .clk        (clk),
                        .rst_n_i    (rst_n_i),
                        .in_flit_i  (in_flit_i),
                        .out_free_i (out_free[o]),
                        .enable_i   (enable),
                        .rotate_i   (rotate[o]),
                        .grant_o    (grant[o])
                );
                assign granted[o] = |grant[o];
        end

        // An input is ready when any output grants it.
        always_comb begin
                in_ready_o = '0;
                for (int o = 0; o < NUM_PORTS; o++) in_ready_o = in_ready_o | grant[o];
        end

        switch_crossbar u_xbar (
                .clk         (clk),
                .rst_n_i     (rst_n_i),
                .in_flit_i   (in_flit_i),
                .grant_i     (grant),
                .out_ready_i (out_ready_i),
                .out_free_o  (out_free),
                .out_flit_o  (out_flit_o)
        );

        arb_ctrl u_ctrl (
                .clk       (clk),
                .rst_n_i   (rst_n_i),
                .apb_req_i (apb_req_i),
                .apb_rsp_o (apb_rsp_o),
                .granted_i (granted),
                .enable_o  (enable),
                .rotate_o  (rotate)
        );

endmodule

`default_nettype wire

/* hdl/switch_crossbar.sv */
// Crossbar with one output register per port.
// An output register is free when empty or when it drains in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module switch_crossbar (
        input  wire                                                        clk,
        input  wire                                                        rst_n_i,
        input  noc_types_pkg::flit_t [noc_types_pkg::NUM_PORTS-1:0]        in_flit_i,
        input  wire  [noc_types_pkg::NUM_PORTS-1:0][noc_types_pkg::NUM_PORTS-1:0] grant_i,
        input  wire  [noc_types_pkg::NUM_PORTS-1:0]                        out_ready_i,
        output logic [noc_types_pkg::NUM_PORTS-1:0]                        out_free_o,
        output noc_types_pkg::flit_t [noc_types_pkg::NUM_PORTS-1:0]        out_flit_o
);

        import noc_types_pkg::*;

        flit_t [NUM_PORTS-1:0] sel_flit;                // Granted input per output.
        flit_t [NUM_PORTS-1:0] data_q;                  // Held flit contents.
        logic  [NUM_PORTS-1:0] valid_q;                 // Output register occupied.

        // Grants are one-hot, so an OR mux is enough.
        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        sel_flit[o] = '0;
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                if (grant_i[o][i]) sel_flit[o] = sel_flit[o] | in_flit_i[i];
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        valid_q <= '0;
                end else begin
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                if (|grant_i[o]) valid_q[o] <= 1'b1;
                                else if (out_ready_i[o]) valid_q[o] <= 1'b0;   // Drained.
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        if (|grant_i[o]) data_q[o] <= sel_flit[o];
                end
        end

        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        out_free_o[o]          = !valid_q[o] || out_ready_i[o];
                        out_flit_o[o].valid    = valid_q[o];
                        out_flit_o[o].next_dir = data_q[o].next_dir;
                        out_flit_o[o].payload  = data_q[o].payload;
                end
        end

        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_chk
                a_grant_when_free: assert property (@(posedge clk) disable iff (!rst_n_i)
                        |grant_i[o] |-> out_free_o[o])
                        else $error("Output %0d granted while stalled.", o);
        end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the router switch testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
top=router_switch_tb

verilator --binary --timing --assert -j 0 --top-module "$top" \
        -f compile.f -o "${top}_sim"
if [ $? -ne 0 ]; then
        echo "Verilator build failed."
        exit 1
fi

./obj_dir/"${top}_sim" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
        echo "Simulation reported a failure."
        exit 1
fi
if [ "$sim_status" -ne 0 ]; then
        echo "Simulator exited with status $sim_status."
        exit 1
fi
echo "Simulation finished without failures."
exit 0
